// File: build.f
+incdir+common
common/uart_pkg.sv
common/uart_tx_if.sv
common/uart_rx_if.sv
logic/uart_bit_timer.sv
logic/uart_ctrl.sv
uart_phy/uart_transmitter.sv
uart_phy/uart_receiver.sv
logic/uart_top.sv
dv/uart_checker.sv
dv/tb_uart.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_uart
FILELIST  := build.f
VFLAGS    := --binary --assert --timescale 1ns/1ps -j 0 -Wno-fatal

OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(shell grep -v '^+' $(FILELIST))
HDRS      := $(wildcard common/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/tb_uart.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_cfg.svh"

module tb_uart;

    localparam int N_TESTS  = 6;
    localparam int N_FRAMES = 8;
    localparam int MAX_DIV  = 19;
    localparam int CLK_NS   = 20;
    // twelve bit periods per frame at the slowest divider
    localparam int WATCHDOG_NS = N_TESTS * N_FRAMES * 12 * (MAX_DIV + 1) * CLK_NS + 20000;

    logic                   clk;
    logic                   resetn;
    uart_pkg::uart_addr_t   addr;
    logic                   wr;
    logic                   rd;
    uart_pkg::uart_word_t   wdata;
    uart_pkg::uart_word_t   rdata;
    logic                   uart_tx;
    logic                   uart_rx;
    logic                   line_sel;   // 0 loopback, 1 own driver
    logic                   drv_line;
    logic [31 : 0]          lfsr_q;
    int                     bit_p;      // bit period in cycles

    assign uart_rx = line_sel ? drv_line : uart_tx;

    uart_top dut_i
    (
        .clk     (clk),
        .resetn  (resetn),
        .addr    (addr),
        .wr      (wr),
        .rd      (rd),
        .wdata   (wdata),
        .rdata   (rdata),
        .uart_tx (uart_tx),
        .uart_rx (uart_rx)
    );

    uart_checker chk_i
    (
        .clk     (clk),
        .resetn  (resetn),
        .addr    (addr),
        .wr      (wr),
        .rd      (rd),
        .wdata   (wdata),
        .rdata   (rdata),
        .uart_tx (uart_tx)
    );

    always #(CLK_NS / 2) clk = ~clk;

    // taps 32, 22, 2, 1
    function automatic logic [31 : 0] lfsr_step(input logic [31 : 0] s);
        return {s[30 : 0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [31 : 0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_q = lfsr_step(lfsr_q);
            v      = {v[30 : 0], lfsr_q[0]};
        end
    endtask

    task automatic bus_write(input uart_pkg::uart_reg_e a, input uart_pkg::uart_word_t d);
        @(posedge clk);
        addr  <= a;
        wdata <= d;
        wr    <= 1'b1;
        @(posedge clk);
        wr    <= 1'b0;
    endtask

    task automatic bus_read_check(input uart_pkg::uart_reg_e a, input uart_pkg::uart_word_t want);
        @(posedge clk);
        addr <= a;
        rd   <= 1'b1;
        chk_i.expect_read(want);
        @(posedge clk);
        rd   <= 1'b0;
    endtask

    // polls STATUS through rdata alone, so no flag gets cleared
    task automatic wait_idle();
        int n;
        n = 0;
        @(posedge clk);
        addr <= uart_pkg::STATUS_A;
        @(posedge clk);
        while (rdata[0] && n < 14 * bit_p)
        begin
            @(posedge clk);
            n++;
        end
        if (n >= 14 * bit_p)
            chk_i.note_failure("tx_busy did not clear in time");
    endtask

    task automatic set_div();
        logic [31 : 0] r;
        rand_bits(4, r);
        bit_p = 5 + int'(r[3 : 0]);     // divider 4 to 19
        bus_write(uart_pkg::CTRL_A, 16'h0000);
        bus_write(uart_pkg::DIV_A, uart_pkg::uart_word_t'(bit_p - 1));
    endtask

    task automatic drive_frame(input uart_pkg::uart_byte_t b, input logic stop_bit);
        logic [9 : 0] bits;
        bits = {stop_bit, b, 1'b0};
        for (int i = 0; i < 10; i++)
        begin
            @(posedge clk);
            drv_line <= bits[i];
            repeat (bit_p - 1) @(posedge clk);
        end
        @(posedge clk);
        drv_line <= 1'b1;
        repeat (2 * bit_p) @(posedge clk);
    endtask

    task automatic test_reset();
        bus_read_check(uart_pkg::CTRL_A, 16'h0000);
        bus_read_check(uart_pkg::STATUS_A, 16'h0000);
        bus_read_check(uart_pkg::DIV_A, `UART_DIV_RESET);
        repeat (20) @(posedge clk);
        chk_i.end_test("reset");
    endtask

    task automatic test_transmit();
        logic [31 : 0] r;
        set_div();
        bus_write(uart_pkg::CTRL_A, 16'h0001);
        for (int i = 0; i < N_FRAMES; i++)
        begin
            rand_bits(8, r);
            chk_i.expect_frame(r[7 : 0]);
            bus_write(uart_pkg::DATA_A, uart_pkg::uart_word_t'(r[7 : 0]));
            bus_read_check(uart_pkg::STATUS_A, 16'h0001);
            wait_idle();
            bus_read_check(uart_pkg::STATUS_A, 16'h0000);
        end
        chk_i.end_test("transmit");
    endtask

    task automatic test_dropped();
        logic [31 : 0] r;
        set_div();
        bus_write(uart_pkg::CTRL_A, 16'h0001);
        rand_bits(16, r);
        chk_i.expect_frame(r[7 : 0]);
        bus_write(uart_pkg::DATA_A, uart_pkg::uart_word_t'(r[7 : 0]));
        bus_write(uart_pkg::DATA_A, uart_pkg::uart_word_t'(r[15 : 8]));    // busy, dropped
        bus_read_check(uart_pkg::STATUS_A, 16'h0001);
        wait_idle();
        bus_read_check(uart_pkg::STATUS_A, 16'h0000);
        bus_write(uart_pkg::CTRL_A, 16'h0000);
        rand_bits(8, r);
        bus_write(uart_pkg::DATA_A, uart_pkg::uart_word_t'(r[7 : 0]));     // disabled, dropped
        repeat (12 * bit_p) @(posedge clk);
        bus_read_check(uart_pkg::STATUS_A, 16'h0000);
        chk_i.end_test("dropped");
    endtask

    task automatic test_loopback();
        logic [31 : 0] r;
        set_div();
        @(posedge clk);
        line_sel <= 1'b0;
        bus_write(uart_pkg::CTRL_A, 16'h0003);
        for (int i = 0; i < N_FRAMES; i++)
        begin
            rand_bits(8, r);
            chk_i.expect_frame(r[7 : 0]);
            bus_write(uart_pkg::DATA_A, uart_pkg::uart_word_t'(r[7 : 0]));
            wait_idle();
            bus_read_check(uart_pkg::STATUS_A, 16'h0002);
            bus_read_check(uart_pkg::DATA_A, uart_pkg::uart_word_t'(r[7 : 0]));
            bus_read_check(uart_pkg::STATUS_A, 16'h0000);
        end
        chk_i.end_test("loopback");
    endtask

    task automatic test_frame_error();
        logic [31 : 0] r;
        set_div();
        @(posedge clk);
        line_sel <= 1'b1;
        bus_write(uart_pkg::CTRL_A, 16'h0002);
        rand_bits(16, r);
        drive_frame(r[7 : 0], 1'b1);
        bus_read_check(uart_pkg::STATUS_A, 16'h0002);
        drive_frame(r[15 : 8], 1'b0);   // low stop bit
        bus_read_check(uart_pkg::STATUS_A, 16'h0006);
        bus_read_check(uart_pkg::STATUS_A, 16'h0002);
        bus_read_check(uart_pkg::DATA_A, uart_pkg::uart_word_t'(r[7 : 0]));
        bus_read_check(uart_pkg::STATUS_A, 16'h0000);
        chk_i.end_test("frame_err");
    endtask

    task automatic test_abort();
        logic [31 : 0] r;
        logic [31 : 0] cut;
        set_div();
        for (int i = 0; i < N_FRAMES / 2; i++)
        begin
            bus_write(uart_pkg::CTRL_A, 16'h0001);
            rand_bits(8, r);
            bus_write(uart_pkg::DATA_A, uart_pkg::uart_word_t'(r[7 : 0]));
            rand_bits(8, cut);
            repeat (2 + int'(cut) % (8 * bit_p)) @(posedge clk);
            bus_write(uart_pkg::CTRL_A, 16'h0000);
            bus_read_check(uart_pkg::STATUS_A, 16'h0000);
        end
        bus_write(uart_pkg::CTRL_A, 16'h0001);
        rand_bits(8, r);
        chk_i.expect_frame(r[7 : 0]);
        bus_write(uart_pkg::DATA_A, uart_pkg::uart_word_t'(r[7 : 0]));
        wait_idle();
        bus_read_check(uart_pkg::STATUS_A, 16'h0000);
        chk_i.end_test("abort");
    endtask

    initial
    begin
        clk      = 1'b0;
        resetn   = 1'b0;
        addr     = '0;
        wr       = 1'b0;
        rd       = 1'b0;
        wdata    = '0;
        line_sel = 1'b0;
        drv_line = 1'b1;
        lfsr_q   = 32'ha1852b87;
        bit_p    = `UART_DIV_RESET + 1;
        repeat (4) @(posedge clk);
        resetn <= 1'b1;
        test_reset();
        test_transmit();
        test_dropped();
        test_loopback();
        test_frame_error();
        test_abort();
        chk_i.print_totals();
        if (chk_i.error_count() == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("Something failed");
        $finish;
    end

endmodule : tb_uart

`default_nettype wire

// File: dv/uart_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_cfg.svh"

module uart_checker
(
    input   logic                   clk,
    input   logic                   resetn,
    input   uart_pkg::uart_addr_t   addr,
    input   logic                   wr,
    input   logic                   rd,
    input   uart_pkg::uart_word_t   wdata,
    input   uart_pkg::uart_word_t   rdata,
    input   logic                   uart_tx
);

    uart_pkg::uart_byte_t   exp_tx[$];      // bytes that must show up on the line
    uart_pkg::uart_word_t   exp_rd[$];      // values for the next checked reads
    uart_pkg::uart_div_t    div_m;          // divider as last written on the bus
    uart_pkg::uart_byte_t   dec_shift;
    logic                   tx_on_m;
    logic                   line_q;
    logic                   dec_busy;
    int                     off_age;
    int                     dec_bit;
    int                     dec_wait;
    int                     errors = 0;
    int                     checks = 0;
    int                     tests = 0;
    int                     test_errors = 0;
    int                     test_checks = 0;

    task automatic fail_value(input string msg);
        $display("FAIL at %0t ns: %s", $time, msg);
        errors++;
        test_errors++;
    endtask

    task automatic note_failure(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        errors++;
        test_errors++;
    endtask

    task automatic expect_frame(input uart_pkg::uart_byte_t b);
        exp_tx.push_back(b);
    endtask

    task automatic expect_read(input uart_pkg::uart_word_t v);
        exp_rd.push_back(v);
    endtask

    task automatic compare_read();
        uart_pkg::uart_word_t want;
        if (exp_rd.size() == 0)
            note_failure("register read with no expected value queued");
        else
        begin
            want = exp_rd.pop_front();
            checks++;
            test_checks++;
            if (rdata !== want)
                fail_value($sformatf("read of register %0d gave %04h, expected %04h",
                                     addr, rdata, want));
        end
    endtask

    task automatic finish_frame();
        uart_pkg::uart_byte_t want;
        if (exp_tx.size() == 0)
            note_failure("a frame appeared on uart_tx with no byte queued");
        else
        begin
            want = exp_tx.pop_front();
            checks++;
            test_checks++;
            if (dec_shift !== want)
                fail_value($sformatf("frame carried %02h, expected %02h", dec_shift, want));
        end
    endtask

    // one sample per bit middle, bit 0 is the start bit
    task automatic decode_step();
        if (dec_wait > 0)
            dec_wait--;
        else
        begin
            if (dec_bit == 0 && uart_tx !== 1'b0)
            begin
                fail_value("start bit not low at its middle");
                dec_busy = 1'b0;
            end
            else if (dec_bit >= 1 && dec_bit <= `UART_DATA_W)
                dec_shift = {uart_tx, dec_shift[`UART_DATA_W-1 : 1]};   // lsb first
            else if (dec_bit == `UART_DATA_W + 1)
            begin
                if (uart_tx !== 1'b1)
                    fail_value("stop bit low on uart_tx");
                finish_frame();
                dec_busy = 1'b0;
            end
            dec_bit++;
            dec_wait = int'(div_m);     // next middle one period later
        end
    endtask

    task automatic end_test(input string name);
        @(posedge clk);     // last read of the test is compared on this edge
        if (exp_tx.size() != 0)
            note_failure($sformatf("%0d frames never seen on uart_tx", exp_tx.size()));
        if (exp_rd.size() != 0)
            note_failure($sformatf("%0d expected reads never happened", exp_rd.size()));
        exp_tx.delete();
        exp_rd.delete();
        tests++;
        $display("test %-10s %-6s checks %0d, errors %0d", name,
                 (test_errors == 0) ? "passed" : "failed", test_checks, test_errors);
        test_errors = 0;
        test_checks = 0;
    endtask

    function automatic int error_count();
        return errors;
    endfunction

    task automatic print_totals();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    endtask

    always @(posedge clk)
    begin
        if (!resetn)
        begin
            div_m    = `UART_DIV_RESET;
            tx_on_m  = 1'b0;
            off_age  = 2;
            line_q   = 1'b1;
            dec_busy = 1'b0;
        end
        else
        begin
            // line must be idle once transmit has been off for a cycle
            if (!tx_on_m && off_age >= 1 && uart_tx !== 1'b1)
                fail_value("uart_tx low while transmit disabled");
            if (!tx_on_m && off_age < 2)
                off_age++;
            if (rd)
                compare_read();
            if (dec_busy)
                decode_step();
            else if (tx_on_m && line_q && !uart_tx)
            begin
                dec_busy = 1'b1;
                dec_bit  = 0;
                dec_wait = (int'(div_m) + 1) / 2 - 1;
            end
            if (wr && addr == uart_pkg::CTRL_A)
            begin
                tx_on_m = wdata[0];
                if (!wdata[0])
                begin
                    off_age  = 0;
                    dec_busy = 1'b0;    // frame in flight is cut off
                end
            end
            if (wr && addr == uart_pkg::DIV_A)
                div_m = wdata;
            line_q = uart_tx;
        end
    end

endmodule : uart_checker

`default_nettype wire

// File: logic/uart_top.sv
`timescale 1ns/1ps
`default_nettype none

module uart_top
(
    input   logic                   clk,
    input   logic                   resetn,
    input   uart_pkg::uart_addr_t   addr,
    input   logic                   wr,
    input   logic                   rd,
    input   uart_pkg::uart_word_t   wdata,
    output  uart_pkg::uart_word_t   rdata,
    output  logic                   uart_tx,
    input   logic                   uart_rx
);

    uart_pkg::uart_div_t    div;
    logic                   tx_tick;
    logic                   rx_mid;
    logic                   rx_restart;

    uart_tx_if tx_if ();
    uart_rx_if rx_if ();

    uart_ctrl ctrl_i
    (
        .clk     (clk),
        .resetn  (resetn),
        .addr    (addr),
        .wr      (wr),
        .rd      (rd),
        .wdata   (wdata),
        .rdata   (rdata),
        .div     (div),
        .tx      (tx_if.ctrl),
        .rx      (rx_if.ctrl)
    );

    // held in restart while transmit is off
    uart_bit_timer tx_timer_i
    (
        .clk     (clk),
        .resetn  (resetn),
        .div     (div),
        .restart (!tx_if.tr_en),
        .tick    (tx_tick),
        .mid     ()
    );

    uart_bit_timer rx_timer_i
    (
        .clk     (clk),
        .resetn  (resetn),
        .div     (div),
        .restart (rx_restart),
        .tick    (),
        .mid     (rx_mid)
    );

    uart_transmitter transmitter_i
    (
        .clk     (clk),
        .resetn  (resetn),
        .en      (tx_tick),
        .tx      (tx_if.phy),
        .uart_tx (uart_tx)
    );

    uart_receiver receiver_i
    (
        .clk     (clk),
        .resetn  (resetn),
        .uart_rx (uart_rx),
        .sample  (rx_mid),
        .restart (rx_restart),
        .rx      (rx_if.phy)
    );

endmodule : uart_top

`default_nettype wire

// File: uart_phy/uart_receiver.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_cfg.svh"

module uart_receiver
(
    input   logic       clk,
    input   logic       resetn,
    input   logic       uart_rx,
    input   logic       sample,     // mid-bit strobe
    output  logic       restart,    // realigns the bit timer
    uart_rx_if.phy      rx
);

    localparam int BIT_W = $clog2(`UART_DATA_W);

    logic [1 : 0]           sync;
    logic                   line;
    logic                   line_q;
    logic [BIT_W-1 : 0]     bit_cnt;
    uart_pkg::uart_byte_t   shift;
    logic                   valid_q;
    logic                   ferr_q;
    uart_pkg::rx_state_e    state;

    assign line         = sync[1];
    assign restart      = rx.rec_en && (state == uart_pkg::IDLE) && line_q && !line;
    assign rx.rx_data   = shift;
    assign rx.rx_valid  = valid_q;
    assign rx.frame_err = ferr_q;

    // two-flop synchronizer plus one for the edge
    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
        begin
            sync   <= 2'b11;
            line_q <= 1'b1;
        end
        else
        begin
            sync   <= {sync[0], uart_rx};
            line_q <= line;
        end
    end

    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
        begin
            state   <= uart_pkg::IDLE;
            bit_cnt <= '0;
            valid_q <= 1'b0;
            ferr_q  <= 1'b0;
        end
        else
        begin
            valid_q <= 1'b0;
            ferr_q  <= 1'b0;
            if (!rx.rec_en)
                state <= uart_pkg::IDLE;
            else
            begin
                case (state)
                    uart_pkg::IDLE  : if (restart) state <= uart_pkg::START;
                    uart_pkg::START :
                        if (sample)
                        begin
                            bit_cnt <= '0;
                            // a high line here was only a glitch
                            state   <= line ? uart_pkg::IDLE : uart_pkg::DATA;
                        end
                    uart_pkg::DATA  :
                        if (sample)
                        begin
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == BIT_W'(`UART_DATA_W - 1))
                                state <= uart_pkg::STOP;
                        end
                    uart_pkg::STOP  :
                        if (sample)
                        begin
                            valid_q <= line;
                            ferr_q  <= !line;
                            state   <= uart_pkg::IDLE;
                        end
                    default         : state <= uart_pkg::IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == uart_pkg::DATA && sample)
            shift <= {line, shift[`UART_DATA_W-1 : 1]};    // lsb arrives first
    end

endmodule : uart_receiver

`default_nettype wire

// File: uart_phy/uart_transmitter.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_cfg.svh"

module uart_transmitter
(
    input   logic       clk,
    input   logic       resetn,
    input   logic       en,         // bit strobe
    uart_tx_if.phy      tx,
    output  logic       uart_tx
);

    localparam int CNT_W = $clog2(`UART_DATA_W) + 1;

    uart_pkg::uart_byte_t   int_reg;    // shift copy of tx_data
    logic [CNT_W-1 : 0]     counter;
    logic                   tr2wait;
    logic                   ack_q;

    enum logic [1 : 0] { WAIT_s, START_s, TRANSMIT_s, STOP_s } state, next_state;

    assign tr2wait    = counter == CNT_W'(`UART_DATA_W);
    assign tx.req_ack = ack_q;

    // WAIT leaves on req without waiting for en
    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
            state <= WAIT_s;
        else if (!tx.tr_en)
            state <= WAIT_s;            // abort
        else if (en || state == WAIT_s)
            state <= next_state;
    end

    always_comb
    begin
        next_state = state;
        case (state)
            WAIT_s     : if (tx.req) next_state = START_s;
            START_s    : next_state = TRANSMIT_s;
            TRANSMIT_s : if (tr2wait) next_state = STOP_s;
            STOP_s     : next_state = WAIT_s;
            default    : next_state = WAIT_s;
        endcase
    end

    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
        begin
            counter <= '0;
            int_reg <= '1;
            uart_tx <= 1'b1;
            ack_q   <= 1'b0;
        end
        else
        begin
            ack_q <= 1'b0;
            if (!tx.tr_en)
            begin
                counter <= '0;
                int_reg <= '1;
                uart_tx <= 1'b1;    // line back to idle
            end
            else if (en)
            begin
                case (state)
                    WAIT_s     : uart_tx <= 1'b1;
                    START_s    :
                    begin
                        int_reg <= tx.tx_data;
                        uart_tx <= 1'b0;            // start bit
                        counter <= '0;
                    end
                    TRANSMIT_s :
                    begin
                        uart_tx <= int_reg[counter[CNT_W-2 : 0]];  // lsb first
                        counter <= counter + 1'b1;
                        if (tr2wait)
                        begin
                            counter <= '0;
                            uart_tx <= 1'b1;
                        end
                    end
                    STOP_s     : ack_q <= 1'b1;
                    default    : uart_tx <= 1'b1;
                endcase
            end
        end
    end

    ack_one_cycle_a : assert property (@(posedge clk) disable iff (!resetn)
        tx.req_ack |=> !tx.req_ack);

endmodule : uart_transmitter

`default_nettype wire

// File: logic/uart_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_cfg.svh"

module uart_ctrl
(
    input   logic                   clk,
    input   logic                   resetn,
    input   uart_pkg::uart_addr_t   addr,
    input   logic                   wr,
    input   logic                   rd,
    input   uart_pkg::uart_word_t   wdata,
    output  uart_pkg::uart_word_t   rdata,
    output  uart_pkg::uart_div_t    div,
    uart_tx_if.ctrl                 tx,
    uart_rx_if.ctrl                 rx
);

    logic                   tx_en;
    logic                   rx_en;
    uart_pkg::uart_div_t    div_q;
    uart_pkg::uart_byte_t   tx_data_q;
    uart_pkg::uart_byte_t   rx_data_q;
    logic                   req_q;
    logic                   tx_busy;
    logic                   rx_full;
    logic                   rx_ferr;
    logic                   data_wr;
    logic                   tx_start;
    logic                   data_rd;
    logic                   status_rd;

    assign data_wr   = wr && (addr == uart_pkg::DATA_A);
    assign tx_start  = data_wr && tx_en && !tx_busy;   // anything else is dropped
    assign data_rd   = rd && (addr == uart_pkg::DATA_A);
    assign status_rd = rd && (addr == uart_pkg::STATUS_A);

    assign div        = div_q;
    assign tx.tr_en   = tx_en;
    assign tx.tx_data = tx_data_q;
    assign tx.req     = req_q;
    assign rx.rec_en  = rx_en;

    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
        begin
            tx_en <= 1'b0;
            rx_en <= 1'b0;
            div_q <= `UART_DIV_RESET;
        end
        else if (wr)
        begin
            case (uart_pkg::uart_reg_e'(addr))
                uart_pkg::CTRL_A : {rx_en, tx_en} <= wdata[1 : 0];
                uart_pkg::DIV_A  : div_q <= wdata;
                default          : ;                // data handled below, status read only
            endcase
        end
    end

    // transmit side, busy from accepted write until ack or disable
    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
        begin
            req_q   <= 1'b0;
            tx_busy <= 1'b0;
        end
        else
        begin
            req_q <= tx_start;
            if (tx_start)
                tx_busy <= 1'b1;
            else if (tx.req_ack || !tx_en)  // aborted frame gives no ack
                tx_busy <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (tx_start)
            tx_data_q <= wdata[`UART_DATA_W-1 : 0];
        if (rx.rx_valid)
            rx_data_q <= rx.rx_data;    // unread character is overwritten
    end

    // sticky receive flags, a new event wins over a clearing read
    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
        begin
            rx_full <= 1'b0;
            rx_ferr <= 1'b0;
        end
        else
        begin
            if (rx.rx_valid)
                rx_full <= 1'b1;
            else if (data_rd)
                rx_full <= 1'b0;
            if (rx.frame_err)
                rx_ferr <= 1'b1;
            else if (status_rd)
                rx_ferr <= 1'b0;
        end
    end

    always_comb
    begin
        rdata = '0;
        case (uart_pkg::uart_reg_e'(addr))
            uart_pkg::CTRL_A   : rdata = uart_pkg::uart_word_t'({rx_en, tx_en});
            uart_pkg::DIV_A    : rdata = div_q;
            uart_pkg::DATA_A   : rdata = uart_pkg::uart_word_t'(rx_data_q);
            uart_pkg::STATUS_A : rdata = uart_pkg::uart_word_t'({rx_ferr, rx_full, tx_busy});
            default            : rdata = '0;
        endcase
    end

    // a request must never meet the end of a frame still in flight
    req_while_busy_a : assert property (@(posedge clk) disable iff (!resetn)
        tx.req |-> (tx_busy && !tx.req_ack));

endmodule : uart_ctrl

`default_nettype wire

// File: logic/uart_bit_timer.sv
`timescale 1ns/1ps
`default_nettype none

module uart_bit_timer
(
    input   logic                   clk,
    input   logic                   resetn,
    input   uart_pkg::uart_div_t    div,
    input   logic                   restart,
    output  logic                   tick,
    output  logic                   mid
);

    uart_pkg::uart_div_t    cnt;
    uart_pkg::uart_div_t    half;

    // rounds up so mid lands at period/2 after restart
    assign half = (div >> 1) + uart_pkg::uart_div_t'(div[0]);

    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
            cnt <= '0;
        else if (restart || cnt == '0)
            cnt <= div;             // div+1 cycles per period
        else
            cnt <= cnt - 1'b1;
    end

    assign tick = !restart && (cnt == '0);
    assign mid  = !restart && (cnt == half);

    tick_mid_apart_a : assert property (@(posedge clk) disable iff (!resetn)
        (div > 1) |-> !(tick && mid));

endmodule : uart_bit_timer

`default_nettype wire

// File: common/uart_rx_if.sv
`timescale 1ns/1ps
`default_nettype none

interface uart_rx_if;

    logic                   rec_en;     // receive enable
    uart_pkg::uart_byte_t   rx_data;    // last character shifted in
    logic                   rx_valid;   // pulse, good stop bit
    logic                   frame_err;  // pulse, stop bit low

    modport ctrl
    (
        output  rec_en,
        input   rx_data, rx_valid, frame_err
    );

    modport phy
    (
        input   rec_en,
        output  rx_data, rx_valid, frame_err
    );

endinterface : uart_rx_if

`default_nettype wire

// File: common/uart_tx_if.sv
`timescale 1ns/1ps
`default_nettype none

interface uart_tx_if;

    logic                   tr_en;      // transmit enable
    uart_pkg::uart_byte_t   tx_data;    // held stable while busy
    logic                   req;        // one-cycle start pulse
    logic                   req_ack;    // one-cycle end of frame

    modport ctrl
    (
        output  tr_en, tx_data, req,
        input   req_ack
    );

    modport phy
    (
        input   tr_en, tx_data, req,
        output  req_ack
    );

endinterface : uart_tx_if

`default_nettype wire

// File: common/uart_pkg.sv
`default_nettype none

`include "uart_cfg.svh"

package uart_pkg;

    typedef logic [`UART_DATA_W-1 : 0]  uart_byte_t;
    typedef logic [`UART_DIV_W-1 : 0]   uart_div_t;
    typedef logic [`UART_ADDR_W-1 : 0]  uart_addr_t;
    typedef logic [`UART_DIV_W-1 : 0]   uart_word_t;   // wide enough for the divider

    // register map
    typedef enum logic [`UART_ADDR_W-1 : 0]
    {
        CTRL_A   = 2'd0,
        DIV_A    = 2'd1,
        DATA_A   = 2'd2,
        STATUS_A = 2'd3
    } uart_reg_e;

    typedef enum logic [1 : 0] { IDLE, START, DATA, STOP } rx_state_e;

endpackage : uart_pkg

`default_nettype wire

// File: common/uart_cfg.svh
`ifndef UART_CFG_SVH
`define UART_CFG_SVH

// character width, fixed 8N1 framing
`define UART_DATA_W     8

// baud divider width, bit period is divider plus one cycles
`define UART_DIV_W      16

// four registers on the bus
`define UART_ADDR_W     2

// 115200 baud from a 50 MHz clock
`define UART_DIV_RESET  16'd433

`endif
